// ==== mem_axil_bridge.f ====
logic/mem_axil_pkg.sv
logic/axil_write_lanes.sv
logic/axil_read_pack.sv
logic/axil_resp_timer.sv
logic/axil_master_fsm.sv
logic/mem_axil_bridge.sv
test/axil_mem_model.sv
test/tb_mem_axil_bridge.sv

// ==== test/tb_mem_axil_bridge.sv ====
`timescale 1ns/1ps

module tb_mem_axil_bridge;

  localparam int unsigned WAIT_LIMIT = 400;

  logic                   clk = 1'b0;
  logic                   reset;
  mem_axil_pkg::mem_req_s req;
  mem_axil_pkg::mem_rsp_s rsp;
  logic                   req_valid, req_ready, rsp_valid, rsp_ready;
  logic [31:0]            awaddr, araddr;
  logic                   awvalid, awready, wvalid, wready, bvalid, bready;
  logic                   arvalid, arready, rvalid, rready;
  logic [63:0]            wdata, rdata;
  logic [7:0]             wstrb;
  logic [1:0]             bresp, rresp;
  logic                   stall, err, drop;

  // Scoreboard copy of the target memory
  logic [63:0] sb_mem [16];
  integer      seed = 32'h24fc;
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned req_count = 0;
  int unsigned rsp_count = 0;
  bit          rsp_hold_mode = 1'b0;

  always #2 clk = ~clk;

  mem_axil_bridge u_dut (
    .clk_i(clk), .reset_i(reset),
    .req_i(req), .req_valid_i(req_valid), .req_ready_o(req_ready),
    .rsp_o(rsp), .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready),
    .awaddr_o(awaddr), .awvalid_o(awvalid), .awready_i(awready),
    .wdata_o(wdata), .wstrb_o(wstrb), .wvalid_o(wvalid), .wready_i(wready),
    .bresp_i(bresp), .bvalid_i(bvalid), .bready_o(bready),
    .araddr_o(araddr), .arvalid_o(arvalid), .arready_i(arready),
    .rdata_i(rdata), .rresp_i(rresp), .rvalid_i(rvalid), .rready_o(rready)
  );

  axil_mem_model u_mem (
    .clk_i(clk), .reset_i(reset), .stall_i(stall), .err_i(err), .drop_i(drop),
    .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
    .wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
    .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
    .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
    .rdata_o(rdata), .rresp_o(rresp), .rvalid_o(rvalid), .rready_i(rready)
  );

  // Response handshakes seen on the DUT port
  always @(posedge clk)
  begin
    if (!reset && rsp_valid && rsp_ready)
      rsp_count++;
  end

  function automatic logic [63:0] merge_write(logic [63:0] old, int unsigned off,
                                              int unsigned nbytes, logic [63:0] data);
    logic [63:0] w;
    w = old;
    for (int b = 0; b < 8; b++)
    begin
      if (b >= off && b < off + nbytes)
        w[8*b +: 8] = data[8*(b-off) +: 8];
    end
    return w;
  endfunction

  // Addressed bytes moved down, upper bytes zero
  function automatic logic [63:0] extract_read(logic [63:0] word, int unsigned off,
                                               int unsigned nbytes);
    logic [63:0] v;
    v = '0;
    for (int b = 0; b < nbytes; b++)
      v[8*b +: 8] = word[8*(off+b) +: 8];
    return v;
  endfunction

  function automatic logic [63:0] fill_word(int unsigned idx);
    logic [63:0] w;
    logic [7:0]  a;
    for (int b = 0; b < 8; b++)
    begin
      a = 8'(idx * 8 + b);
      w[8*b +: 8] = (a * 8'h1d) ^ 8'h5a;
    end
    return w;
  endfunction

  task automatic check_value(input string test, input string field,
                             input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp)
      else
      begin
        errors++;
        $display("ERROR %s %s: expected %h, actual %h", test, field, exp, act);
      end
  endtask

  task automatic finish_run();
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  endtask

  task automatic timeout_abort(input string what);
    errors++;
    $display("Timed out waiting for %s", what);
    finish_run();
  endtask

  // One request, one response, with optional rsp_ready back-pressure
  task automatic transact(input string test, input mem_axil_pkg::mem_req_s r,
                          output mem_axil_pkg::mem_rsp_s got);
    int unsigned            cycles;
    int unsigned            hold;
    bit                     seen;
    bit                     done;
    mem_axil_pkg::mem_rsp_s first;
    hold   = rsp_hold_mode ? ($random(seed) & 15) : 0;
    seen   = 1'b0;
    done   = 1'b0;
    cycles = 0;
    first  = '0;
    @(posedge clk);
    req       <= r;
    req_valid <= 1'b1;
    rsp_ready <= !rsp_hold_mode;
    do
    begin
      @(posedge clk);
      cycles++;
      assert (!rsp_valid)
        else
        begin
          errors++;
          $display("Response seen in %s with no request outstanding", test);
        end
    end while (!req_ready && cycles < WAIT_LIMIT);
    if (!req_ready)
      timeout_abort("request acceptance");
    req_valid <= 1'b0;
    req_count++;
    cycles = 0;
    while (!done)
    begin
      @(posedge clk);
      cycles++;
      if (rsp_valid)
      begin
        if (!seen)
        begin
          seen  = 1'b1;
          first = rsp;
        end
        checks++;
        assert (rsp === first)
          else
          begin
            errors++;
            $display("ERROR %s stable rsp: expected %h, actual %h", test, first, rsp);
          end
        if (rsp_ready)
          done = 1'b1;
        else if (hold > 0)
          hold--;
        else
          rsp_ready <= 1'b1;
      end
      if (!done && cycles >= WAIT_LIMIT)
        timeout_abort("response");
    end
    rsp_ready <= !rsp_hold_mode;
    got = first;
  endtask

  task automatic access(input string test, input mem_axil_pkg::msg_type_e kind,
                        input int unsigned idx, input int unsigned off,
                        input mem_axil_pkg::msg_size_e size, input logic [63:0] data,
                        input mem_axil_pkg::rsp_status_e exp_status);
    mem_axil_pkg::mem_req_s r;
    mem_axil_pkg::mem_rsp_s got;
    int unsigned            nbytes;
    logic [63:0]            exp_data;
    nbytes     = 1 << size;
    r.msg_type = kind;
    r.size     = size;
    r.addr     = 32'(idx * 8 + off);
    r.data     = data;
    transact(test, r, got);
    if (kind == mem_axil_pkg::MSG_WR)
      exp_data = data;
    else
      exp_data = extract_read(sb_mem[idx], off, nbytes);
    check_value(test, "type", r.msg_type, got.msg_type);
    check_value(test, "size", r.size, got.size);
    check_value(test, "addr", r.addr, got.addr);
    check_value(test, "status", exp_status, got.status);
    // Read data only means something on success
    if (kind == mem_axil_pkg::MSG_WR || exp_status == mem_axil_pkg::ST_OKAY)
      check_value(test, "data", exp_data, got.data);
    if (kind == mem_axil_pkg::MSG_WR && exp_status == mem_axil_pkg::ST_OKAY)
      sb_mem[idx] = merge_write(sb_mem[idx], off, nbytes, data);
  endtask

  task automatic test_reset_state();
    check_value("reset", "awvalid", 1'b0, awvalid);
    check_value("reset", "wvalid", 1'b0, wvalid);
    check_value("reset", "arvalid", 1'b0, arvalid);
    check_value("reset", "bready", 1'b0, bready);
    check_value("reset", "rready", 1'b0, rready);
    check_value("reset", "rsp_valid", 1'b0, rsp_valid);
    check_value("reset", "req_ready", 1'b1, req_ready);
  endtask

  task automatic fill_memory();
    for (int i = 0; i < 16; i++)
      access("fill", mem_axil_pkg::MSG_WR, i, 0, mem_axil_pkg::SIZE_8, fill_word(i),
             mem_axil_pkg::ST_OKAY);
  endtask

  task automatic test_write_sizes();
    logic [63:0] data;
    for (int s = 0; s < 4; s++)
    begin
      for (int off = 0; off < 8; off += (1 << s))
      begin
        data = {$random(seed), $random(seed)};
        access("write_sizes", mem_axil_pkg::MSG_WR, (s * 5 + off) % 16, off,
               mem_axil_pkg::msg_size_e'(s), data, mem_axil_pkg::ST_OKAY);
        access("write_sizes", mem_axil_pkg::MSG_RD, (s * 5 + off) % 16, 0,
               mem_axil_pkg::SIZE_8, '0, mem_axil_pkg::ST_OKAY);
      end
    end
  endtask

  task automatic test_read_sizes();
    for (int s = 0; s < 4; s++)
    begin
      for (int off = 0; off < 8; off += (1 << s))
        access("read_sizes", mem_axil_pkg::MSG_RD, (s * 3 + off + 7) % 16, off,
               mem_axil_pkg::msg_size_e'(s), '0, mem_axil_pkg::ST_OKAY);
    end
  endtask

  task automatic test_slave_error();
    @(posedge clk);
    err <= 1'b1;
    access("slave_error", mem_axil_pkg::MSG_WR, 5, 2, mem_axil_pkg::SIZE_2,
           64'h0123_4567_89ab_cdef, mem_axil_pkg::ST_SLVERR);
    access("slave_error", mem_axil_pkg::MSG_RD, 9, 4, mem_axil_pkg::SIZE_4, '0,
           mem_axil_pkg::ST_SLVERR);
    @(posedge clk);
    err <= 1'b0;
  endtask

  task automatic test_dropped();
    @(posedge clk);
    drop <= 1'b1;
    access("dropped", mem_axil_pkg::MSG_WR, 3, 4, mem_axil_pkg::SIZE_4,
           64'hfeed_f00d_dead_beef, mem_axil_pkg::ST_TIMEOUT);
    access("dropped", mem_axil_pkg::MSG_RD, 6, 0, mem_axil_pkg::SIZE_8, '0,
           mem_axil_pkg::ST_TIMEOUT);
    @(posedge clk);
    drop <= 1'b0;
    // Bridge recovers and the dropped write left no trace
    access("dropped", mem_axil_pkg::MSG_RD, 3, 0, mem_axil_pkg::SIZE_8, '0,
           mem_axil_pkg::ST_OKAY);
  endtask

  task automatic test_backpressure();
    int unsigned               s;
    int unsigned               off;
    mem_axil_pkg::msg_type_e   kind;
    @(posedge clk);
    stall <= 1'b1;
    rsp_hold_mode = 1'b1;
    for (int n = 0; n < 24; n++)
    begin
      kind = mem_axil_pkg::msg_type_e'($random(seed) & 1);
      s    = $random(seed) & 3;
      off  = (($random(seed) & 7) >> s) << s;
      access("backpressure", kind, $random(seed) & 15, off, mem_axil_pkg::msg_size_e'(s),
             {$random(seed), $random(seed)}, mem_axil_pkg::ST_OKAY);
    end
    rsp_hold_mode = 1'b0;
    @(posedge clk);
    stall <= 1'b0;
    check_value("backpressure", "responses", req_count, rsp_count);
  endtask

  initial
  begin
    reset     = 1'b1;
    req       = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b1;
    stall     = 1'b0;
    err       = 1'b0;
    drop      = 1'b0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    test_reset_state();
    fill_memory();
    test_write_sizes();
    test_read_sizes();
    test_slave_error();
    test_dropped();
    test_backpressure();
    finish_run();
  end

endmodule

// ==== test/axil_mem_model.sv ====
`timescale 1ns/1ps

module axil_mem_model (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            stall_i,
  input  logic                            err_i,
  input  logic                            drop_i,
  input  logic [mem_axil_pkg::ADDR_W-1:0] awaddr_i,
  input  logic                            awvalid_i,
  output logic                            awready_o,
  input  logic [mem_axil_pkg::DATA_W-1:0] wdata_i,
  input  logic [mem_axil_pkg::STRB_W-1:0] wstrb_i,
  input  logic                            wvalid_i,
  output logic                            wready_o,
  output logic [1:0]                      bresp_o,
  output logic                            bvalid_o,
  input  logic                            bready_i,
  input  logic [mem_axil_pkg::ADDR_W-1:0] araddr_i,
  input  logic                            arvalid_i,
  output logic                            arready_o,
  output logic [mem_axil_pkg::DATA_W-1:0] rdata_o,
  output logic [1:0]                      rresp_o,
  output logic                            rvalid_o,
  input  logic                            rready_i
);

  // 16 words of 8 bytes
  logic [mem_axil_pkg::DATA_W-1:0] mem [16];
  logic [3:0]                      aw_idx_q;
  logic [3:0]                      ar_idx_q;
  logic [mem_axil_pkg::DATA_W-1:0] wdata_q;
  logic [mem_axil_pkg::STRB_W-1:0] wstrb_q;
  logic                            aw_got_q;
  logic                            w_got_q;
  logic                            ar_got_q;
  integer                          seed = 32'h24fc;

  always @(posedge clk_i)
  begin : model_seq
    logic [31:0] rnd;
    rnd = $random(seed);
    if (reset_i)
    begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      arready_o <= 1'b0;
      bvalid_o  <= 1'b0;
      rvalid_o  <= 1'b0;
      bresp_o   <= mem_axil_pkg::AXI_RESP_OKAY;
      rresp_o   <= mem_axil_pkg::AXI_RESP_OKAY;
      rdata_o   <= '0;
      aw_got_q  <= 1'b0;
      w_got_q   <= 1'b0;
      ar_got_q  <= 1'b0;
    end
    else
    begin
      // Ready after a random delay when stalling
      if (awvalid_i && awready_o)
      begin
        aw_idx_q  <= awaddr_i[6:3];
        aw_got_q  <= 1'b1;
        awready_o <= 1'b0;
      end
      else
        awready_o <= awvalid_i && !aw_got_q && (!stall_i || rnd[0]);

      if (wvalid_i && wready_o)
      begin
        wdata_q  <= wdata_i;
        wstrb_q  <= wstrb_i;
        w_got_q  <= 1'b1;
        wready_o <= 1'b0;
      end
      else
        wready_o <= wvalid_i && !w_got_q && (!stall_i || rnd[1]);

      // Commit the write once both halves are in
      if (aw_got_q && w_got_q && !bvalid_o && (!stall_i || rnd[2]))
      begin
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
        bvalid_o <= !drop_i;
        bresp_o  <= err_i ? mem_axil_pkg::AXI_RESP_SLVERR : mem_axil_pkg::AXI_RESP_OKAY;
        if (!err_i && !drop_i)
        begin
          for (int b = 0; b < 8; b++)
          begin
            if (wstrb_q[b])
              mem[aw_idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
          end
        end
      end
      else if (bvalid_o && bready_i)
        bvalid_o <= 1'b0;

      if (arvalid_i && arready_o)
      begin
        ar_idx_q  <= araddr_i[6:3];
        ar_got_q  <= 1'b1;
        arready_o <= 1'b0;
      end
      else
        arready_o <= arvalid_i && !ar_got_q && (!stall_i || rnd[3]);

      // A dropped read never raises rvalid
      if (ar_got_q && !rvalid_o && (!stall_i || rnd[4]))
      begin
        ar_got_q <= 1'b0;
        rvalid_o <= !drop_i;
        rdata_o  <= err_i ? '0 : mem[ar_idx_q];
        rresp_o  <= err_i ? mem_axil_pkg::AXI_RESP_SLVERR : mem_axil_pkg::AXI_RESP_OKAY;
      end
      else if (rvalid_o && rready_i)
        rvalid_o <= 1'b0;
    end
  end

endmodule

// ==== logic/mem_axil_bridge.sv ====
`timescale 1ns/1ps

module mem_axil_bridge (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  mem_axil_pkg::mem_req_s            req_i,
  input  logic                              req_valid_i,
  output logic                              req_ready_o,
  output mem_axil_pkg::mem_rsp_s            rsp_o,
  output logic                              rsp_valid_o,
  input  logic                              rsp_ready_i,
  output logic [mem_axil_pkg::ADDR_W-1:0]   awaddr_o,
  output logic                              awvalid_o,
  input  logic                              awready_i,
  output logic [mem_axil_pkg::DATA_W-1:0]   wdata_o,
  output logic [mem_axil_pkg::STRB_W-1:0]   wstrb_o,
  output logic                              wvalid_o,
  input  logic                              wready_i,
  input  logic [1:0]                        bresp_i,
  input  logic                              bvalid_i,
  output logic                              bready_o,
  output logic [mem_axil_pkg::ADDR_W-1:0]   araddr_o,
  output logic                              arvalid_o,
  input  logic                              arready_i,
  input  logic [mem_axil_pkg::DATA_W-1:0]   rdata_i,
  input  logic [1:0]                        rresp_i,
  input  logic                              rvalid_i,
  output logic                              rready_o
);

  mem_axil_pkg::mem_req_s          req_q;
  logic [mem_axil_pkg::DATA_W-1:0] packed_rdata;
  logic                            timer_clear;
  logic                            timer_run;
  logic                            timer_expired;

  // Word-aligned address, byte position travels in strobe and lanes
  assign awaddr_o = {req_q.addr[mem_axil_pkg::ADDR_W-1:mem_axil_pkg::OFFSET_W],
                     {mem_axil_pkg::OFFSET_W{1'b0}}};
  assign araddr_o = awaddr_o;

  axil_master_fsm u_fsm (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .rsp_o          (rsp_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ready_i    (rsp_ready_i),
    .awvalid_o      (awvalid_o),
    .awready_i      (awready_i),
    .wvalid_o       (wvalid_o),
    .wready_i       (wready_i),
    .bresp_i        (bresp_i),
    .bvalid_i       (bvalid_i),
    .bready_o       (bready_o),
    .arvalid_o      (arvalid_o),
    .arready_i      (arready_i),
    .rvalid_i       (rvalid_i),
    .rresp_i        (rresp_i),
    .rready_o       (rready_o),
    .packed_rdata_i (packed_rdata),
    .req_q_o        (req_q),
    .timer_clear_o  (timer_clear),
    .timer_run_o    (timer_run),
    .timer_expired_i(timer_expired)
  );

  axil_resp_timer u_timer (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .clear_i  (timer_clear),
    .run_i    (timer_run),
    .expired_o(timer_expired)
  );

  axil_write_lanes u_wlanes (
    .req_i  (req_q),
    .wdata_o(wdata_o),
    .wstrb_o(wstrb_o)
  );

  axil_read_pack u_rpack (
    .rdata_i (rdata_i),
    .size_i  (req_q.size),
    .offset_i(req_q.addr[mem_axil_pkg::OFFSET_W-1:0]),
    .data_o  (packed_rdata)
  );

endmodule

// ==== logic/axil_master_fsm.sv ====
`timescale 1ns/1ps

module axil_master_fsm (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  mem_axil_pkg::mem_req_s          req_i,
  input  logic                            req_valid_i,
  output logic                            req_ready_o,
  output mem_axil_pkg::mem_rsp_s          rsp_o,
  output logic                            rsp_valid_o,
  input  logic                            rsp_ready_i,
  output logic                            awvalid_o,
  input  logic                            awready_i,
  output logic                            wvalid_o,
  input  logic                            wready_i,
  input  logic [1:0]                      bresp_i,
  input  logic                            bvalid_i,
  output logic                            bready_o,
  output logic                            arvalid_o,
  input  logic                            arready_i,
  input  logic                            rvalid_i,
  input  logic [1:0]                      rresp_i,
  output logic                            rready_o,
  input  logic [mem_axil_pkg::DATA_W-1:0] packed_rdata_i,
  output mem_axil_pkg::mem_req_s          req_q_o,
  output logic                            timer_clear_o,
  output logic                            timer_run_o,
  input  logic                            timer_expired_i
);

  typedef enum logic [2:0] {
    S_IDLE, S_WR_AW, S_WR_B, S_RD_AR, S_RD_R, S_RESP
  } state_e;

  state_e                          state_q, state_d;
  mem_axil_pkg::mem_req_s          req_q;
  mem_axil_pkg::mem_rsp_s          rsp_q;
  logic                            aw_done_q, w_done_q;
  logic                            aw_ok, w_ok;
  logic                            rsp_load;
  mem_axil_pkg::rsp_status_e       status_d;
  logic [mem_axil_pkg::DATA_W-1:0] rsp_data_d;

  assign req_ready_o = (state_q == S_IDLE);
  assign awvalid_o   = (state_q == S_WR_AW) && !aw_done_q;
  assign wvalid_o    = (state_q == S_WR_AW) && !w_done_q;
  assign bready_o    = (state_q == S_WR_B);
  assign arvalid_o   = (state_q == S_RD_AR);
  assign rready_o    = (state_q == S_RD_R);
  assign rsp_valid_o = (state_q == S_RESP);
  assign rsp_o       = rsp_q;
  assign req_q_o     = req_q;

  // Timer counts only while an AXI channel is open
  assign timer_clear_o = (state_q == S_IDLE);
  assign timer_run_o   = !(state_q inside {S_IDLE, S_RESP});

  // aw and w may complete in either order
  assign aw_ok = aw_done_q || awready_i;
  assign w_ok  = w_done_q || wready_i;

  always_comb
  begin
    state_d    = state_q;
    rsp_load   = 1'b0;
    status_d   = mem_axil_pkg::ST_TIMEOUT;
    rsp_data_d = req_q.data;
    case (state_q)
      S_IDLE:
      begin
        if (req_valid_i)
          state_d = (req_i.msg_type == mem_axil_pkg::MSG_WR) ? S_WR_AW : S_RD_AR;
      end
      S_WR_AW:
      begin
        if (aw_ok && w_ok)
        begin
          state_d = S_WR_B;
        end
        else if (timer_expired_i)
        begin
          state_d  = S_RESP;
          rsp_load = 1'b1;
        end
      end
      S_WR_B:
      begin
        if (bvalid_i || timer_expired_i)
        begin
          state_d  = S_RESP;
          rsp_load = 1'b1;
          if (bvalid_i)
            status_d = (bresp_i == mem_axil_pkg::AXI_RESP_OKAY) ?
                       mem_axil_pkg::ST_OKAY : mem_axil_pkg::ST_SLVERR;
        end
      end
      S_RD_AR:
      begin
        if (arready_i)
        begin
          state_d = S_RD_R;
        end
        else if (timer_expired_i)
        begin
          state_d    = S_RESP;
          rsp_load   = 1'b1;
          rsp_data_d = '0;
        end
      end
      S_RD_R:
      begin
        if (rvalid_i || timer_expired_i)
        begin
          state_d    = S_RESP;
          rsp_load   = 1'b1;
          rsp_data_d = '0;
          if (rvalid_i)
          begin
            rsp_data_d = packed_rdata_i;
            status_d   = (rresp_i == mem_axil_pkg::AXI_RESP_OKAY) ?
                         mem_axil_pkg::ST_OKAY : mem_axil_pkg::ST_SLVERR;
          end
        end
      end
      S_RESP:
      begin
        if (rsp_ready_i)
          state_d = S_IDLE;
      end
      default:
      begin
        state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_q   <= S_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == S_WR_AW)
      begin
        aw_done_q <= aw_ok;
        w_done_q  <= w_ok;
      end
      else
      begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i)
  begin
    if (req_valid_i && req_ready_o)
      req_q <= req_i;
    if (rsp_load)
    begin
      rsp_q.msg_type <= req_q.msg_type;
      rsp_q.size     <= req_q.size;
      rsp_q.addr     <= req_q.addr;
      rsp_q.data     <= rsp_data_d;
      rsp_q.status   <= status_d;
    end
  end

  // Address valids hold until accepted unless the transaction times out
  a_aw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    awvalid_o && !awready_i && !timer_expired_i |=> awvalid_o)
    else $error("awvalid dropped before awready");

  a_ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    arvalid_o && !arready_i && !timer_expired_i |=> arvalid_o)
    else $error("arvalid dropped before arready");

  // A pending response stays put and keeps new requests out until taken
  a_rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && !req_ready_o && $stable(rsp_o))
    else $error("response changed or dropped before rsp_ready");

endmodule

// ==== logic/axil_resp_timer.sv ====
`timescale 1ns/1ps

module axil_resp_timer (
  input  logic clk_i,
  input  logic reset_i,
  input  logic clear_i,
  input  logic run_i,
  output logic expired_o
);

  logic [mem_axil_pkg::TIMER_W-1:0] count_q;

  // Saturates at the timeout value
  always_ff @(posedge clk_i)
  begin
    if (reset_i || clear_i)
    begin
      count_q <= '0;
    end
    else if (run_i && !expired_o)
    begin
      count_q <= count_q + 1'b1;
    end
  end

  assign expired_o = (count_q == mem_axil_pkg::RESP_TIMEOUT);

  // Expiry can only follow a cycle of counting
  a_expire_needs_run: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(expired_o) |-> $past(run_i))
    else $error("timer expired without running");

endmodule

// ==== logic/axil_read_pack.sv ====
`timescale 1ns/1ps

module axil_read_pack (
  input  logic [mem_axil_pkg::DATA_W-1:0]   rdata_i,
  input  mem_axil_pkg::msg_size_e           size_i,
  input  logic [mem_axil_pkg::OFFSET_W-1:0] offset_i,
  output logic [mem_axil_pkg::DATA_W-1:0]   data_o
);

  logic [mem_axil_pkg::DATA_W-1:0] shifted;
  logic [mem_axil_pkg::DATA_W-1:0] keep;

  // Addressed lane down to byte 0
  assign shifted = rdata_i >> {offset_i, 3'b000};

  // Bytes kept for each access size
  always_comb
  begin
    case (size_i)
      mem_axil_pkg::SIZE_1:
      begin
        keep = 64'h0000_0000_0000_00ff;
      end
      mem_axil_pkg::SIZE_2:
      begin
        keep = 64'h0000_0000_0000_ffff;
      end
      mem_axil_pkg::SIZE_4:
      begin
        keep = 64'h0000_0000_ffff_ffff;
      end
      default:
      begin
        keep = 64'hffff_ffff_ffff_ffff;
      end
    endcase
  end

  // Zero-extend above the access size
  assign data_o = shifted & keep;

endmodule

// ==== logic/axil_write_lanes.sv ====
`timescale 1ns/1ps

module axil_write_lanes (
  input  mem_axil_pkg::mem_req_s                req_i,
  output logic [mem_axil_pkg::DATA_W-1:0]       wdata_o,
  output logic [mem_axil_pkg::STRB_W-1:0]       wstrb_o
);

  logic [mem_axil_pkg::OFFSET_W-1:0] offset;
  logic [mem_axil_pkg::OFFSET_W-1:0] align_bits;
  logic [mem_axil_pkg::STRB_W-1:0]   size_strb;

  assign offset = req_i.addr[mem_axil_pkg::OFFSET_W-1:0];

  // Strobe of the access size and the offset bits that must be zero
  always_comb
  begin
    case (req_i.size)
      mem_axil_pkg::SIZE_1:
      begin
        size_strb  = 8'h01;
        align_bits = 3'b000;
      end
      mem_axil_pkg::SIZE_2:
      begin
        size_strb  = 8'h03;
        align_bits = 3'b001;
      end
      mem_axil_pkg::SIZE_4:
      begin
        size_strb  = 8'h0f;
        align_bits = 3'b011;
      end
      default:
      begin
        size_strb  = 8'hff;
        align_bits = 3'b111;
      end
    endcase
  end

  // Move data and strobe up to the addressed byte lanes
  assign wstrb_o = size_strb << offset;
  assign wdata_o = req_i.data << {offset, 3'b000};

  always_comb
  begin
    if (req_i.msg_type == mem_axil_pkg::MSG_WR)
    begin
      assert #0 ((offset & align_bits) == '0)
        else $error("misaligned write to %h, size code %0d", req_i.addr, req_i.size);
    end
  end

endmodule

// ==== logic/mem_axil_pkg.sv ====
package mem_axil_pkg;

  // Bus and request widths
  localparam int unsigned DATA_W   = 64;
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned STRB_W   = DATA_W / 8;
  localparam int unsigned OFFSET_W = 3;

  // Response timer
  localparam int unsigned TIMER_W = 7;
  localparam logic [TIMER_W-1:0] RESP_TIMEOUT = 7'd64;

  // AXI response codes
  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

  typedef enum logic {
    MSG_RD = 1'b0,
    MSG_WR = 1'b1
  } msg_type_e;

  // Encoded as log2 of the byte count
  typedef enum logic [1:0] {
    SIZE_1 = 2'd0,
    SIZE_2 = 2'd1,
    SIZE_4 = 2'd2,
    SIZE_8 = 2'd3
  } msg_size_e;

  typedef enum logic [1:0] {
    ST_OKAY    = 2'd0,
    ST_SLVERR  = 2'd1,
    ST_TIMEOUT = 2'd2
  } rsp_status_e;

  // Write data sits in the low bytes
  typedef struct packed {
    msg_type_e         msg_type;
    msg_size_e         size;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } mem_req_s;

  // Read data comes back shifted down and zero-extended
  typedef struct packed {
    msg_type_e         msg_type;
    msg_size_e         size;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    rsp_status_e       status;
  } mem_rsp_s;

endpackage
